// ==== common/llm_pkg.sv ====
// Page list manager constants
`default_nettype none

package llm_pkg;

  // page numbering
  localparam int PAGE_W    = 4;
  localparam int NUM_PAGES = 16;

  // link entry is a page number plus a stop flag in the msb
  localparam int NEXT_W = PAGE_W + 1;

  // chain terminator, stop bit only
  localparam logic [NEXT_W-1:0] STOP_NEXT = {1'b1, {PAGE_W{1'b0}}};

  // packet length in pages, 1 to 4
  localparam int LEN_W         = 3;
  localparam int MAX_PKT_PAGES = 4;

  // list manager commands
  localparam int CMD_W = 2;

  // pop a page from the free list
  localparam logic [CMD_W-1:0] CMD_ALLOC = 2'd0;
  // write the link entry of a page
  localparam logic [CMD_W-1:0] CMD_LINK  = 2'd1;
  // return the link entry of a page
  localparam logic [CMD_W-1:0] CMD_READ  = 2'd2;
  // push a page back on the free list
  localparam logic [CMD_W-1:0] CMD_FREE  = 2'd3;

endpackage

`default_nettype wire

// ==== common/llm_cmd_if.sv ====
// List manager command channel
`timescale 1ns/1ps
`default_nettype none

interface llm_cmd_if;

  logic                      cmd_srdy;
  logic                      cmd_drdy;
  logic [llm_pkg::CMD_W-1:0]  cmd_op;
  logic [llm_pkg::PAGE_W-1:0] cmd_page;
  logic [llm_pkg::NEXT_W-1:0] cmd_next;

  // one pulse per accepted command
  logic                      rsp_srdy;
  logic [llm_pkg::PAGE_W-1:0] rsp_page;
  logic [llm_pkg::NEXT_W-1:0] rsp_next;

  modport client (
    output cmd_srdy, cmd_op, cmd_page, cmd_next,
    input  cmd_drdy, rsp_srdy, rsp_page, rsp_next
  );

  modport manager (
    input  cmd_srdy, cmd_op, cmd_page, cmd_next,
    output cmd_drdy, rsp_srdy, rsp_page, rsp_next
  );

endinterface

`default_nettype wire

// ==== llm/llm_cmd_decode.sv ====
// List manager command arbiter
`timescale 1ns/1ps
`default_nettype none

module llm_cmd_decode (
  input logic        clk,
  input logic        rst_n,
  llm_cmd_if.manager lnk,
  llm_cmd_if.manager wlk,
  llm_cmd_if.client  core
);

  // 0 selects the linker, 1 the walker
  logic pick;
  logic grant;
  logic busy;
  logic take;

  // round robin on contention, else whoever asks
  always_comb
  begin
    if (lnk.cmd_srdy && wlk.cmd_srdy)
      pick = ~grant;
    else
      pick = wlk.cmd_srdy;
  end

  // nothing new goes out while a response is pending
  assign core.cmd_srdy = ~busy & (pick ? wlk.cmd_srdy : lnk.cmd_srdy);
  assign core.cmd_op   = pick ? wlk.cmd_op : lnk.cmd_op;
  assign core.cmd_page = pick ? wlk.cmd_page : lnk.cmd_page;
  assign core.cmd_next = pick ? wlk.cmd_next : lnk.cmd_next;

  assign lnk.cmd_drdy = ~busy & ~pick & core.cmd_drdy;
  assign wlk.cmd_drdy = ~busy & pick & core.cmd_drdy;

  assign take = core.cmd_srdy & core.cmd_drdy;

  // response goes to the holder of the grant
  assign lnk.rsp_srdy = busy & ~grant & core.rsp_srdy;
  assign wlk.rsp_srdy = busy & grant & core.rsp_srdy;
  assign lnk.rsp_page = core.rsp_page;
  assign wlk.rsp_page = core.rsp_page;
  assign lnk.rsp_next = core.rsp_next;
  assign wlk.rsp_next = core.rsp_next;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      grant <= 1'b0;
    end
    else if (take)
    begin
      busy  <= 1'b1;
      grant <= pick;
    end
    else if (core.rsp_srdy)
      busy <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== llm/llm_list_core.sv ====
// Free list and link memory
`timescale 1ns/1ps
`default_nettype none

module llm_list_core (
  input  logic                      clk,
  input  logic                      rst_n,
  llm_cmd_if.manager                cmd,
  output logic [llm_pkg::PAGE_W:0]  free_count
);

  // free pages, top of stack at sp-1
  logic [llm_pkg::PAGE_W-1:0] stack [llm_pkg::NUM_PAGES];
  logic [llm_pkg::PAGE_W:0]   sp;
  logic [llm_pkg::PAGE_W-1:0] top;

  // next pointer per page
  logic [llm_pkg::NEXT_W-1:0] link_mem [llm_pkg::NUM_PAGES];

  logic empty;
  logic take;

  assign empty = (sp == '0);
  assign top   = sp[llm_pkg::PAGE_W-1:0] - 1'b1;

  // only an alloc on an empty list stalls
  assign cmd.cmd_drdy = ~(empty && (cmd.cmd_op == llm_pkg::CMD_ALLOC));

  assign take       = cmd.cmd_srdy & cmd.cmd_drdy;
  assign free_count = sp;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // full list, page 0 on top
      sp           <= {1'b1, {llm_pkg::PAGE_W{1'b0}}};
      cmd.rsp_srdy <= 1'b0;
      for (int i = 0; i < llm_pkg::NUM_PAGES; i++)
      begin
        stack[i] <= ~i[llm_pkg::PAGE_W-1:0];
      end
    end
    else
    begin
      cmd.rsp_srdy <= take;
      if (take)
      begin
        case (cmd.cmd_op)
          llm_pkg::CMD_ALLOC:
            sp <= sp - 1'b1;
          llm_pkg::CMD_FREE:
          begin
            stack[sp[llm_pkg::PAGE_W-1:0]] <= cmd.cmd_page;
            sp                            <= sp + 1'b1;
          end
          default:
            sp <= sp;
        endcase
      end
    end
  end

  // link writes and response data
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      case (cmd.cmd_op)
        llm_pkg::CMD_ALLOC:
          cmd.rsp_page <= stack[top];
        llm_pkg::CMD_LINK:
          link_mem[cmd.cmd_page] <= cmd.cmd_next;
        llm_pkg::CMD_READ:
          cmd.rsp_next <= link_mem[cmd.cmd_page];
        default:
          cmd.rsp_page <= cmd.rsp_page;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/pkt_linker.sv ====
// Packet page chain builder
`timescale 1ns/1ps
`default_nettype none

module pkt_linker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pkt_srdy,
  input  logic [llm_pkg::LEN_W-1:0]  pkt_len,
  output logic                       pkt_drdy,
  llm_cmd_if.client                  lm,
  output logic                       head_srdy,
  output logic [llm_pkg::PAGE_W-1:0] head_page,
  input  logic                       head_drdy
);

  logic alloc_st;
  logic link_st;
  logic pend;
  logic last_idx;

  logic [llm_pkg::LEN_W-1:0]  len;
  logic [llm_pkg::LEN_W-1:0]  idx;
  logic [llm_pkg::LEN_W-1:0]  idx_nxt;
  logic [llm_pkg::PAGE_W-1:0] pages [llm_pkg::MAX_PKT_PAGES];

  assign pkt_drdy = ~(alloc_st | link_st | head_srdy);
  assign last_idx = (idx == len - 1'b1);
  assign idx_nxt  = idx + 1'b1;

  // one command in flight, allocs first then links
  assign lm.cmd_srdy = (alloc_st | link_st) & ~pend;
  assign lm.cmd_op   = alloc_st ? llm_pkg::CMD_ALLOC : llm_pkg::CMD_LINK;
  assign lm.cmd_page = pages[idx[llm_pkg::LEN_W-2:0]];
  assign lm.cmd_next = last_idx ? llm_pkg::STOP_NEXT
                                : {1'b0, pages[idx_nxt[llm_pkg::LEN_W-2:0]]};

  assign head_page = pages[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      alloc_st  <= 1'b0;
      link_st   <= 1'b0;
      head_srdy <= 1'b0;
      pend      <= 1'b0;
      idx       <= '0;
    end
    else
    begin
      if (pkt_srdy && pkt_drdy)
      begin
        alloc_st <= 1'b1;
        idx      <= '0;
      end
      if (lm.cmd_srdy && lm.cmd_drdy)
        pend <= 1'b1;
      if (lm.rsp_srdy)
      begin
        pend <= 1'b0;
        if (!last_idx)
          idx <= idx_nxt;
        else if (alloc_st)
        begin
          // all pages in hand, start linking from the head
          alloc_st <= 1'b0;
          link_st  <= 1'b1;
          idx      <= '0;
        end
        else
        begin
          link_st   <= 1'b0;
          head_srdy <= 1'b1;
        end
      end
      if (head_srdy && head_drdy)
        head_srdy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pkt_srdy && pkt_drdy)
      len <= pkt_len;
    if (alloc_st && lm.rsp_srdy)
      pages[idx[llm_pkg::LEN_W-2:0]] <= lm.rsp_page;
  end

endmodule

`default_nettype wire

// ==== design/pkt_walker.sv ====
// Page chain walker
`timescale 1ns/1ps
`default_nettype none

module pkt_walker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       head_srdy,
  input  logic [llm_pkg::PAGE_W-1:0] head_page,
  output logic                       head_drdy,
  llm_cmd_if.client                  lm,
  output logic                       out_srdy,
  output logic [llm_pkg::PAGE_W-1:0] out_page,
  output logic                       out_last,
  input  logic                       out_drdy
);

  logic rd_st;
  logic free_st;
  logic pend;

  logic [llm_pkg::PAGE_W-1:0] page;
  logic [llm_pkg::PAGE_W-1:0] nxt;

  assign head_drdy = ~(rd_st | out_srdy | free_st);

  // read the link, present the page, then free it
  assign lm.cmd_srdy = (rd_st | free_st) & ~pend;
  assign lm.cmd_op   = rd_st ? llm_pkg::CMD_READ : llm_pkg::CMD_FREE;
  assign lm.cmd_page = page;
  // walker never writes links
  assign lm.cmd_next = '0;

  assign out_page = page;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_st    <= 1'b0;
      out_srdy <= 1'b0;
      free_st  <= 1'b0;
      pend     <= 1'b0;
    end
    else
    begin
      if (head_srdy && head_drdy)
        rd_st <= 1'b1;
      if (lm.cmd_srdy && lm.cmd_drdy)
        pend <= 1'b1;
      if (lm.rsp_srdy)
      begin
        pend <= 1'b0;
        if (rd_st)
        begin
          rd_st    <= 1'b0;
          out_srdy <= 1'b1;
        end
        else
        begin
          free_st <= 1'b0;
          rd_st   <= ~out_last;
        end
      end
      if (out_srdy && out_drdy)
      begin
        out_srdy <= 1'b0;
        free_st  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (head_srdy && head_drdy)
      page <= head_page;
    else if (free_st && lm.rsp_srdy)
      page <= nxt;
    if (rd_st && lm.rsp_srdy)
    begin
      nxt      <= lm.rsp_next[llm_pkg::PAGE_W-1:0];
      out_last <= (lm.rsp_next == llm_pkg::STOP_NEXT);
    end
  end

endmodule

`default_nettype wire

// ==== design/page_ll_top.sv ====
// Linked list page manager top
`timescale 1ns/1ps
`default_nettype none

module page_ll_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pkt_srdy,
  output logic                       pkt_drdy,
  input  logic [llm_pkg::LEN_W-1:0]  pkt_len,
  output logic                       out_srdy,
  input  logic                       out_drdy,
  output logic [llm_pkg::PAGE_W-1:0] out_page,
  output logic                       out_last,
  output logic [llm_pkg::PAGE_W:0]   free_count
);

  llm_cmd_if lnk_if ();
  llm_cmd_if wlk_if ();
  llm_cmd_if core_if ();

  // head queue from linker to walker
  logic                       head_srdy;
  logic                       head_drdy;
  logic [llm_pkg::PAGE_W-1:0] head_page;

  pkt_linker linker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_srdy  (pkt_srdy),
    .pkt_len   (pkt_len),
    .pkt_drdy  (pkt_drdy),
    .lm        (lnk_if.client),
    .head_srdy (head_srdy),
    .head_page (head_page),
    .head_drdy (head_drdy)
  );

  pkt_walker walker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .head_srdy (head_srdy),
    .head_page (head_page),
    .head_drdy (head_drdy),
    .lm        (wlk_if.client),
    .out_srdy  (out_srdy),
    .out_page  (out_page),
    .out_last  (out_last),
    .out_drdy  (out_drdy)
  );

  llm_cmd_decode decode_i (
    .clk   (clk),
    .rst_n (rst_n),
    .lnk   (lnk_if.manager),
    .wlk   (wlk_if.manager),
    .core  (core_if.client)
  );

  llm_list_core core_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (core_if.manager),
    .free_count (free_count)
  );

endmodule

`default_nettype wire

// ==== tests/tb_page_ll.sv ====
// Page list manager testbench
`timescale 1ns/1ps
`default_nettype none

module tb_page_ll;

  localparam int CLK_PER = 100;
  localparam int NUM_REC = 16;
  localparam int REC_W   = 7;
  // unlisted page, or lfsr stalls when in the stall column
  localparam logic [7:0] NONE = 8'hff;

  logic                       clk;
  logic                       rst_n;
  logic                       pkt_srdy;
  logic                       pkt_drdy;
  logic [llm_pkg::LEN_W-1:0]  pkt_len;
  logic                       out_srdy;
  logic                       out_drdy;
  logic [llm_pkg::PAGE_W-1:0] out_page;
  logic                       out_last;
  logic [llm_pkg::PAGE_W:0]   free_count;

  logic [7:0]                 stim [NUM_REC*REC_W];
  // free list model, front is the next page handed out
  logic [llm_pkg::PAGE_W-1:0] free_q [$];
  logic [llm_pkg::PAGE_W-1:0] model_pages [llm_pkg::MAX_PKT_PAGES];
  logic [15:0]                lfsr;
  int                         errors;
  int                         checks;
  int                         tests;
  // output transfers seen on the port
  int                         out_xfers;

  page_ll_top dut_i (.*);

  always #(CLK_PER / 2) clk = ~clk;

  // srdy and drdy both high here means a transfer on the next rising edge
  always @(negedge clk)
  begin
    if (rst_n && out_srdy && out_drdy)
      out_xfers++;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // stall of 0 to 3 cycles from two lfsr bits
  function automatic int rand_stall();
    int st;
    st = 0;
    for (int b = 0; b < 2; b++)
    begin
      lfsr = lfsr_next(lfsr);
      st   = st * 2 + lfsr[0];
    end
    return st;
  endfunction

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("%s ok", name);
    else
      $display("%s done with %0d errors", name, errors - err_before);
  endtask

  task automatic send_pkt(input logic [llm_pkg::LEN_W-1:0] len);
    @(posedge clk);
    pkt_srdy <= 1'b1;
    pkt_len  <= len;
    @(negedge clk);
    while (!pkt_drdy)
      @(negedge clk);
    @(posedge clk);
    pkt_srdy <= 1'b0;
  endtask

  // collect one packet at the output and check its chain
  task automatic recv_chain(input int r, input bit use_model);
    string                      name;
    int                         stall;
    logic [7:0]                 exp;
    logic [llm_pkg::PAGE_W-1:0] pg;
    logic                       last;
    logic [15:0]                seen;
    name = $sformatf("test %0d", stim[r*REC_W]);
    seen = '0;
    for (int i = 0; i < stim[r*REC_W+1]; i++)
    begin
      if (stim[r*REC_W+2] == NONE)
        stall = rand_stall();
      else
        stall = stim[r*REC_W+2];
      @(negedge clk);
      while (!out_srdy)
        @(negedge clk);
      pg   = out_page;
      last = out_last;
      // page and last flag hold while stalled
      repeat (stall)
      begin
        @(negedge clk);
        if (!out_srdy || out_page !== pg || out_last !== last)
        begin
          errors++;
          $display("%s: output changed while out_drdy was low", name);
        end
      end
      @(posedge clk);
      out_drdy <= 1'b1;
      @(posedge clk);
      out_drdy <= 1'b0;
      if (use_model)
      begin
        exp = (stim[r*REC_W+3+i] == NONE) ? model_pages[i] : stim[r*REC_W+3+i];
        check_val($sformatf("%s page %0d", name, i), exp, pg);
        // walker frees pages in output order
        free_q.push_front(model_pages[i]);
      end
      check_val($sformatf("%s last %0d", name, i), i == stim[r*REC_W+1] - 1, last);
      if (seen[pg])
      begin
        errors++;
        $display("%s: page %0d came out twice in one packet", name, pg);
      end
      seen[pg] = 1'b1;
    end
  endtask

  // frees trail the last output page by a few cycles
  task automatic wait_free_full(input string name);
    int n;
    n = 0;
    while (free_count != llm_pkg::NUM_PAGES && n < 40)
    begin
      @(negedge clk);
      n++;
    end
    check_val({name, " free_count"}, llm_pkg::NUM_PAGES, free_count);
  endtask

  initial
  begin
    int first;
    int e0;
    int xfer0;
    int want;
    clk       = 1'b0;
    rst_n     = 1'b0;
    pkt_srdy  = 1'b0;
    pkt_len   = '0;
    out_drdy  = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    out_xfers = 0;
    lfsr      = 16'd4678;
    $readmemh("tests/page_ll_stimulus.txt", stim);
    for (int i = 0; i < llm_pkg::NUM_PAGES; i++)
      free_q.push_back(i);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    e0 = errors;
    check_val("test reset free_count", llm_pkg::NUM_PAGES, free_count);
    check_val("test reset out_srdy", 0, out_srdy);
    check_val("test reset pkt_drdy", 1, pkt_drdy);
    report_test("test reset", e0);

    // one packet at a time, drained before the next
    first = 0;
    while (first < NUM_REC && stim[first*REC_W+2] != NONE)
    begin
      e0 = errors;
      for (int i = 0; i < stim[first*REC_W+1]; i++)
        model_pages[i] = free_q.pop_front();
      send_pkt(stim[first*REC_W+1][llm_pkg::LEN_W-1:0]);
      recv_chain(first, 1'b1);
      wait_free_full($sformatf("test %0d", stim[first*REC_W]));
      report_test($sformatf("test %0d", stim[first*REC_W]), e0);
      first++;
    end

    // remaining records back to back, linker runs ahead of the walker
    e0    = errors;
    xfer0 = out_xfers;
    want  = 0;
    for (int r = first; r < NUM_REC; r++)
      want += stim[r*REC_W+1];
    fork
      for (int r = first; r < NUM_REC; r++)
        send_pkt(stim[r*REC_W+1][llm_pkg::LEN_W-1:0]);
      for (int r = first; r < NUM_REC; r++)
        recv_chain(r, 1'b0);
    join
    check_val("test overlap page total", want, out_xfers - xfer0);
    wait_free_full("test overlap");
    report_test("test overlap", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // run limit scales with the number of records
  initial
  begin
    #(NUM_REC * 200 * CLK_PER);
    $display("timeout: run did not finish within %0d cycles", NUM_REC * 200);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/page_ll_stimulus.txt ====
// id len stall exp0 exp1 exp2 exp3, all hex
// stall ff runs the record overlapped with lfsr stalls, exp ff comes from the stack model
01 1 00 00 ff ff ff
02 2 00 00 01 ff ff
03 3 02 01 00 02 ff
04 4 03 02 00 01 03
05 2 01 ff ff ff ff
06 4 00 ff ff ff ff
07 1 05 ff ff ff ff
08 3 04 ff ff ff ff
// overlapped records
09 3 ff ff ff ff ff
0a 4 ff ff ff ff ff
0b 2 ff ff ff ff ff
0c 1 ff ff ff ff ff
0d 4 ff ff ff ff ff
0e 3 ff ff ff ff ff
0f 2 ff ff ff ff ff
10 4 ff ff ff ff ff

// ==== filelist.f ====
common/llm_pkg.sv
common/llm_cmd_if.sv
llm/llm_cmd_decode.sv
llm/llm_list_core.sv
design/pkt_linker.sv
design/pkt_walker.sv
design/page_ll_top.sv
tests/tb_page_ll.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the page list manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_page_ll -f filelist.f \
  -o tb_page_ll > sim.log 2>&1 \
  && ./obj_dir/tb_page_ll >> sim.log 2>&1 \
  || { echo "build or simulation did not complete" >> sim.log; cat sim.log; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
exit 0
